// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int unsigned data_width = 8;
    localparam int unsigned addr_width = 16;

    // Low byte of the reset vector, high byte sits at the next address
    localparam logic [addr_width-1:0] reset_vector   = 16'hfffc;
    localparam logic [data_width-1:0] zero_page_high = 8'h00;

    localparam logic [7:0] opcode_jmp_abs = 8'h4c;
    localparam logic [7:0] opcode_clc     = 8'h18;
    localparam logic [7:0] opcode_sec     = 8'h38; // Differs from CLC only in bit 5
    localparam logic [7:0] opcode_ldx_imm = 8'ha2;
    localparam logic [7:0] opcode_ldy_imm = 8'ha0;
    localparam logic [7:0] opcode_ldx_zp  = 8'ha6;
    localparam logic [7:0] opcode_ldy_zp  = 8'ha4;
    localparam logic [7:0] opcode_stx_zp  = 8'h86;
    localparam logic [7:0] opcode_sty_zp  = 8'h84;

    // Operation field, opcode bits 7 to 5
    localparam logic [2:0] alu_op_sta = 3'd4;
    localparam logic [2:0] alu_op_lda = 3'd5;

    // One-hot cycle state
    typedef struct packed {
        logic byte1;    // Opcode fetch, writeback of the previous instruction
        logic byte2;    // Operand or low address byte
        logic byte3;    // High address byte of JMP
        logic zeropage; // Zero-page read or store
        logic vector;   // Settle cycle after the reset vector load
    } cycle_state_t;

    typedef struct packed {
        struct packed {
            logic increment;
            logic load_vector; // PC from data_in and the registered low byte
        } pc;
        struct packed {
            logic sel_pc;
            logic sel_zero_page;
        } addr;
        struct packed {
            logic enable;
            logic src_a;
            logic src_x;
            logic src_y;
        } write;
        struct packed {
            logic from_data;
            logic from_alu;
        } db;
        struct packed {
            logic a;
            logic x;
            logic y;
        } dest;
        struct packed {
            logic nz;    // N and Z from the internal bus
            logic alu_c;
            logic alu_v;
            logic ir5_c; // CLC and SEC
        } flag;
    } control_t;

    typedef struct packed {
        logic immediate;
        logic zero_page;
        logic alu_op;    // ALU column, STA excluded
        logic load_x;
        logic load_y;
        logic store;
        logic jmp_abs;
        logic carry_op;
    } decode_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        logic [data_width-1:0] a;
        logic [data_width-1:0] x;
        logic [data_width-1:0] y;
        logic [addr_width-1:0] pc;
        flags_t                flags;
    } reg_view_t;

    typedef struct packed {
        logic [addr_width-1:0] address;
        logic [data_width-1:0] write_data;
        logic                  write_enable;
    } bus_req_t;

endpackage : cpu_pkg

`default_nettype wire

// ==== rtl/bus_input.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_input (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::data_width-1:0] data_in,
    input  cpu_pkg::cycle_state_t          state,
    output logic [cpu_pkg::data_width-1:0] data,
    output logic [cpu_pkg::data_width-1:0] opcode
);
    import cpu_pkg::*;

    // Read data, one cycle behind the bus
    always_ff @(posedge clock)
    begin
        if (enable)
            data <= data_in;
    end

    // Opcode stays put until the next fetch
    // so the previous instruction can write back in byte1
    always_ff @(posedge clock)
    begin
        if (reset)
            opcode <= opcode_jmp_abs; // Reset reuses the JMP tail
        else if (enable && state.byte1)
            opcode <= data_in;
    end

endmodule : bus_input

`default_nettype wire

// ==== rtl/sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module sequencer (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::data_width-1:0] opcode,
    output cpu_pkg::cycle_state_t          state,
    output cpu_pkg::decode_t               decode,
    output cpu_pkg::control_t              control
);
    import cpu_pkg::*;

    cycle_state_t next_state;
    logic         booting;       // Reset vector fetch still running
    logic         alu_writeback; // Previous opcode returns an ALU result
    logic         is_cmp;
    logic         is_adc_sbc;

    // Opcode classes
    assign decode.immediate = (opcode ==? 8'b???_010_01)
                              || opcode == opcode_ldx_imm
                              || opcode == opcode_ldy_imm;
    assign decode.zero_page = (opcode ==? 8'b???_001_01)
                              || opcode == opcode_ldx_zp
                              || opcode == opcode_ldy_zp
                              || opcode == opcode_stx_zp
                              || opcode == opcode_sty_zp;
    assign decode.alu_op    = opcode[1:0] == 2'b01 && opcode[7:5] != alu_op_sta;
    assign decode.load_x    = opcode == opcode_ldx_imm || opcode == opcode_ldx_zp;
    assign decode.load_y    = opcode == opcode_ldy_imm || opcode == opcode_ldy_zp;
    assign decode.store     = opcode == {alu_op_sta, 5'b001_01} // STA zp, 85
                              || opcode == opcode_stx_zp
                              || opcode == opcode_sty_zp;
    assign decode.jmp_abs   = opcode == opcode_jmp_abs;
    assign decode.carry_op  = opcode == opcode_clc || opcode == opcode_sec;

    // Other addressing modes of the ALU column fall through as no-ops
    assign alu_writeback = decode.alu_op && (decode.immediate || decode.zero_page);
    assign is_cmp        = opcode[7:5] == 3'b110; // Leaves A alone
    assign is_adc_sbc    = opcode[6:5] == 2'b11;  // ADC 011, SBC 111

    always_comb
    begin
        control    = '0;
        next_state = '0;

        if (state.byte1)
        begin
            control.addr.sel_pc  = 1'b1; // Opcode fetch
            control.pc.increment = 1'b1;
            next_state.byte2     = 1'b1;

            // Writeback for the opcode still held in the register
            control.db.from_alu  = alu_writeback;
            control.db.from_data = decode.load_x || decode.load_y;
            control.dest.a       = alu_writeback && !is_cmp;
            control.dest.x       = decode.load_x;
            control.dest.y       = decode.load_y;
            control.flag.nz      = alu_writeback || decode.load_x || decode.load_y;
            control.flag.alu_c   = alu_writeback && (is_adc_sbc || is_cmp);
            control.flag.alu_v   = alu_writeback && is_adc_sbc;
            control.flag.ir5_c   = decode.carry_op;
        end

        if (state.byte2)
        begin
            control.addr.sel_pc  = 1'b1; // Operand byte
            control.pc.increment = 1'b1;
            next_state.zeropage  = decode.zero_page;
            next_state.byte3     = decode.jmp_abs;
            next_state.byte1     = !decode.zero_page && !decode.jmp_abs;
        end

        if (state.byte3)
        begin
            // High byte read here, PC loads at the closing edge
            control.addr.sel_pc     = 1'b1;
            control.pc.load_vector  = 1'b1;
            next_state.vector       = booting;
            next_state.byte1        = !booting;
        end

        if (state.zeropage)
        begin
            control.addr.sel_zero_page = 1'b1;
            control.write.enable       = decode.store;
            control.write.src_a        = decode.store && opcode[1:0] == 2'b01;
            control.write.src_x        = decode.store && opcode[1:0] == 2'b10;
            control.write.src_y        = decode.store && opcode[1:0] == 2'b00;
            next_state.byte1           = 1'b1;
        end

        if (state.vector)
        begin
            control.addr.sel_pc = 1'b1; // New PC on the bus, no fetch yet
            next_state.byte1    = 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state   <= '{byte2: 1'b1, default: 1'b0}; // Low vector byte next
            booting <= 1'b1;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state.byte3)
                booting <= 1'b0;
        end
    end

    state_one_hot: assert property (@(posedge clock) disable iff (reset)
        $onehot(state))
        else $error("sequencer state is not one-hot");

    // Stores reach memory only in their zero-page cycle
    write_in_zeropage: assert property (@(posedge clock) disable iff (reset)
        control.write.enable |-> state.zeropage)
        else $error("write enable outside zeropage state");

endmodule : sequencer

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::data_width-1:0] operand_a,
    input  logic [cpu_pkg::data_width-1:0] operand_b,
    input  logic                           carry_in,
    input  logic [2:0]                     op,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           carry_out,
    output logic                           overflow_out
);
    import cpu_pkg::*;

    logic [data_width-1:0] addend;
    logic                  carry;
    logic [data_width:0]   sum;    // Carry in the top bit

    assign addend = op[2] ? ~operand_b : operand_b; // CMP and SBC subtract
    assign carry  = carry_in || op == 3'b110;       // CMP ignores C
    assign sum    = {1'b0, operand_a} + {1'b0, addend} + (data_width + 1)'(carry);

    always_comb
    begin
        case (op)
            3'd0:       result = operand_a | operand_b; // ORA
            3'd1:       result = operand_a & operand_b; // AND
            3'd2:       result = operand_a ^ operand_b; // EOR
            alu_op_sta: result = '0;
            alu_op_lda: result = operand_b;
            default:    result = sum[data_width-1:0];   // ADC CMP SBC
        endcase
    end

    assign carry_out = sum[data_width];
    // Signed overflow when both inputs agree in sign and the sum does not
    assign overflow_out = (operand_a[data_width-1] ^ sum[data_width-1])
                          & (addend[data_width-1] ^ sum[data_width-1]);

endmodule : alu

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module register_file (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  cpu_pkg::control_t              control,
    input  logic [cpu_pkg::data_width-1:0] data_in,      // Live bus, high byte of vector
    input  logic [cpu_pkg::data_width-1:0] data,
    input  logic [cpu_pkg::data_width-1:0] opcode,
    input  logic [cpu_pkg::data_width-1:0] alu_result,
    input  logic                           alu_carry,
    input  logic                           alu_overflow,
    output cpu_pkg::reg_view_t             regs
);
    import cpu_pkg::*;

    logic [data_width-1:0] db;         // Internal data bus
    flags_t                next_flags;

    assign db = control.db.from_alu  ? alu_result :
                control.db.from_data ? data : '0;

    always_comb
    begin
        next_flags = regs.flags;
        if (control.flag.nz)
        begin
            next_flags.n = db[data_width-1];
            next_flags.z = db == '0;
        end
        if (control.flag.alu_c)
            next_flags.c = alu_carry;
        if (control.flag.ir5_c)
            next_flags.c = opcode[5]; // CLC 18, SEC 38
        if (control.flag.alu_v)
            next_flags.v = alu_overflow;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            regs.pc    <= reset_vector;
            regs.a     <= '0;
            regs.x     <= '0;
            regs.y     <= '0;
            regs.flags <= '0;
        end
        else if (enable)
        begin
            if (control.pc.load_vector)
                regs.pc <= {data_in, data}; // Low byte came in the cycle before
            else if (control.pc.increment)
                regs.pc <= regs.pc + 16'd1;
            if (control.dest.a)
                regs.a <= db;
            if (control.dest.x)
                regs.x <= db;
            if (control.dest.y)
                regs.y <= db;
            regs.flags <= next_flags;
        end
    end

    pc_source_unique: assert property (@(posedge clock) disable iff (reset)
        !(control.pc.increment && control.pc.load_vector))
        else $error("PC increment and vector load together");

endmodule : register_file

`default_nettype wire

// ==== rtl/bus_output.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_output (
    input  cpu_pkg::control_t              control,
    input  cpu_pkg::reg_view_t             regs,
    input  logic [cpu_pkg::data_width-1:0] data,
    output cpu_pkg::bus_req_t              bus
);
    import cpu_pkg::*;

    // Zero-page address uses the operand byte held from byte2
    assign bus.address =
        (control.addr.sel_pc        ? regs.pc                : '0) |
        (control.addr.sel_zero_page ? {zero_page_high, data} : '0);

    // Store source picked by the opcode's low bits
    assign bus.write_data =
        (control.write.src_a ? regs.a : '0) |
        (control.write.src_x ? regs.x : '0) |
        (control.write.src_y ? regs.y : '0);

    assign bus.write_enable = control.write.enable;

endmodule : bus_output

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_core (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::data_width-1:0] data_in,
    output logic [cpu_pkg::addr_width-1:0] address,
    output logic [cpu_pkg::data_width-1:0] data_out,
    output logic                           write_enable,
    output logic                           sync
);
    import cpu_pkg::*;

    cycle_state_t          state;
    decode_t               decode;
    control_t              control;
    reg_view_t             regs;
    bus_req_t              bus;
    logic [data_width-1:0] data;       // Registered read data
    logic [data_width-1:0] opcode;
    logic [data_width-1:0] alu_result;
    logic                  alu_carry;
    logic                  alu_overflow;

    bus_input bus_input_inst (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .data_in (data_in),
        .state   (state),
        .data    (data),
        .opcode  (opcode)
    );

    sequencer sequencer_inst (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .opcode  (opcode),
        .state   (state),
        .decode  (decode),
        .control (control)
    );

    // A against the fetched operand, carry from the flag register
    alu alu_inst (
        .operand_a    (regs.a),
        .operand_b    (data),
        .carry_in     (regs.flags.c),
        .op           (opcode[7:5]),
        .result       (alu_result),
        .carry_out    (alu_carry),
        .overflow_out (alu_overflow)
    );

    register_file register_file_inst (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .control      (control),
        .data_in      (data_in),
        .data         (data),
        .opcode       (opcode),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .regs         (regs)
    );

    bus_output bus_output_inst (
        .control (control),
        .regs    (regs),
        .data    (data),
        .bus     (bus)
    );

    assign address      = bus.address;
    assign data_out     = bus.write_data;
    assign write_enable = bus.write_enable;
    assign sync         = state.byte1; // High on every opcode fetch

    // Opcode latched in byte1 must still be a zero-page form in its zero-page cycle
    decode_fetch_alu: assert property (@(posedge clock) disable iff (reset)
        state.zeropage |-> decode.zero_page)
        else $error("zeropage state without a zero-page opcode");

endmodule : cpu_core

`default_nettype wire

// ==== dv/cpu_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable,
    input  logic [15:0] address,
    input  logic [7:0]  data_out,
    input  logic        write_enable,
    input  logic        sync,
    output logic        done,
    output int          error_count
);
    logic [7:0]  model_mem [0:65535]; // Reference memory, copied from the program image
    logic [7:0]  ref_a;
    logic [7:0]  ref_x;
    logic [7:0]  ref_y;
    logic        ref_c;
    logic        ref_v;                // Overflow flag
    logic [15:0] vector;
    logic [15:0] exp_pc;
    logic [15:0] next_pc;
    logic        exp_has_write;        // Expected store of the instruction in flight
    logic [15:0] exp_write_addr;
    logic [7:0]  exp_write_data;
    logic        aborted;
    logic        finished;
    logic        hold_pending;         // Previous cycle was stalled
    logic [15:0] held_address;
    logic [7:0]  held_data;
    logic        held_write;
    int          writes_seen;
    int          cycles;
    int          steps;
    int          addr;
    int          reset_checks;
    int          reset_errors;
    int          fetch_checks;
    int          fetch_errors;
    int          write_checks;
    int          write_errors;
    int          stall_checks;
    int          stall_errors;
    int          timeout_errors;

    // Runs one instruction on the reference state, returns the next fetch address
    function automatic logic [15:0] step_instruction(
        input  logic [15:0] pc,
        output logic        has_write,
        output logic [15:0] write_addr,
        output logic [7:0]  write_data
    );
        logic [7:0] opcode;
        logic [7:0] operand;
        logic [7:0] value;
        logic [2:0] op;
        int         wide;
        int         signed_sum;
        opcode     = model_mem[pc];
        operand    = model_mem[pc + 16'd1];
        op         = opcode[7:5];
        has_write  = 1'b0;
        write_addr = {8'h00, operand};
        write_data = 8'h00;
        step_instruction = pc + 16'd2; // Two-byte forms and no-ops
        if (opcode == 8'h4c)
            step_instruction = {model_mem[pc + 16'd2], operand};
        else if (opcode == 8'h18 || opcode == 8'h38)
            ref_c = opcode == 8'h38;
        else if (opcode == 8'h85 || opcode == 8'h86 || opcode == 8'h84)
        begin
            has_write  = 1'b1;
            write_data = opcode == 8'h85 ? ref_a : opcode == 8'h86 ? ref_x : ref_y;
            model_mem[write_addr] = write_data;
        end
        else if (opcode == 8'ha2 || opcode == 8'ha6)
            ref_x = opcode == 8'ha2 ? operand : model_mem[write_addr];
        else if (opcode == 8'ha0 || opcode == 8'ha4)
            ref_y = opcode == 8'ha0 ? operand : model_mem[write_addr];
        else if (opcode[1:0] == 2'b01 && op != 3'd4
                 && (opcode[4:2] == 3'b010 || opcode[4:2] == 3'b001))
        begin
            value = opcode[4:2] == 3'b010 ? operand : model_mem[write_addr];
            case (op)
                3'd0: ref_a = ref_a | value;
                3'd1: ref_a = ref_a & value;
                3'd2: ref_a = ref_a ^ value;
                3'd3:
                begin
                    wide       = int'(ref_a) + int'(value) + int'(ref_c);
                    signed_sum = int'($signed(ref_a)) + int'($signed(value)) + int'(ref_c);
                    ref_c      = wide > 255;
                    ref_v      = signed_sum > 127 || signed_sum < -128;
                    ref_a      = 8'(wide);
                end
                3'd5: ref_a = value;
                3'd6: ref_c = ref_a >= value; // CMP leaves A and V alone
                default:
                begin
                    // SBC borrows when C is clear
                    wide       = int'(ref_a) - int'(value) - int'(!ref_c);
                    signed_sum = int'($signed(ref_a)) - int'($signed(value)) - int'(!ref_c);
                    ref_c      = wide >= 0;
                    ref_v      = signed_sum > 127 || signed_sum < -128;
                    ref_a      = 8'(wide);
                end
            endcase
        end
    endfunction

    task automatic check_write();
        writes_seen++;
        write_checks++;
        if (!exp_has_write || writes_seen > 1)
        begin
            $display("Unexpected write at time %0t to address %h", $time, address);
            write_errors++;
        end
        else if (address !== exp_write_addr || data_out !== exp_write_data)
        begin
            $display("Mismatch at time %0t: write %h to %h, expected %h to %h", $time,
                     data_out, address, exp_write_data, exp_write_addr);
            write_errors++;
        end
    endtask

    // Collects writes until the next completed opcode fetch
    task automatic wait_fetch(input int limit);
        int   count;
        logic fetched;
        count   = 0;
        fetched = 1'b0;
        while (!fetched && count < limit)
        begin
            @(negedge clock);
            count++;
            if (write_enable === 1'b1 && enable)
                check_write();
            fetched = sync === 1'b1 && enable;
        end
        if (!fetched)
        begin
            $display("Timeout at time %0t: no opcode fetch within %0d cycles", $time, limit);
            timeout_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int checks, input int errors);
        $display("Test %0s: %0d checks, %0d errors", name, checks, errors);
    endtask

    initial
    begin
        done = 1'b0;
        error_count = 0;
        aborted = 1'b0;
        finished = 1'b0;
        exp_has_write = 1'b0;
        hold_pending = 1'b0;
        writes_seen = 0;
        reset_checks = 0;
        reset_errors = 0;
        fetch_checks = 0;
        fetch_errors = 0;
        write_checks = 0;
        write_errors = 0;
        stall_checks = 0;
        stall_errors = 0;
        timeout_errors = 0;
        // Register file reset values
        ref_a = 8'h00;
        ref_x = 8'h00;
        ref_y = 8'h00;
        ref_c = 1'b0;
        ref_v = 1'b0;

        cycles = 0;
        while (reset !== 1'b0 && cycles < 20)
        begin
            @(negedge clock);
            cycles++;
            if (reset === 1'b1)
            begin
                reset_checks++;
                if (write_enable !== 1'b0 || sync !== 1'b0)
                begin
                    $display("Mismatch at time %0t: write_enable %b sync %b in reset, expected 0",
                             $time, write_enable, sync);
                    reset_errors++;
                end
            end
        end
        if (reset !== 1'b0)
        begin
            $display("Reset was never released within %0d cycles", cycles);
            timeout_errors++;
            aborted = 1'b1;
        end

        if (!aborted)
        begin
            for (addr = 0; addr < 65536; addr++)
                model_mem[addr] = cpu_tb.memory[addr];
            vector = {model_mem[16'hfffd], model_mem[16'hfffc]};
            wait_fetch(16); // Vector fetch takes three enabled cycles
        end
        if (!aborted)
        begin
            reset_checks++;
            if (address !== vector)
            begin
                $display("Mismatch at time %0t: first fetch at %h, expected vector %h",
                         $time, address, vector);
                reset_errors++;
            end
            report_test("reset vector", reset_checks, reset_errors);
        end

        exp_pc = vector;
        steps  = 0;
        while (!aborted && !finished && steps < 600)
        begin
            next_pc = step_instruction(exp_pc, exp_has_write, exp_write_addr, exp_write_data);
            writes_seen = 0;
            wait_fetch(16);
            if (!aborted)
            begin
                if (exp_has_write && writes_seen == 0)
                begin
                    $display("Missing write at time %0t: store to %h never happened",
                             $time, exp_write_addr);
                    write_checks++;
                    write_errors++;
                end
                fetch_checks++;
                if (address !== next_pc)
                begin
                    $display("Mismatch at time %0t: fetch at %h, expected %h",
                             $time, address, next_pc);
                    fetch_errors++;
                end
                finished = next_pc == exp_pc; // Final jump to itself
                exp_pc   = next_pc;
            end
            steps++;
        end
        if (!aborted && !finished)
        begin
            $display("The program never reached its final jump after %0d steps", steps);
            fetch_errors++;
        end
        if (stall_checks == 0)
        begin
            $display("No stalled cycle was seen, enable never went low");
            stall_errors++;
        end

        report_test("opcode fetch", fetch_checks, fetch_errors);
        report_test("stores", write_checks, write_errors);
        report_test("stall hold", stall_checks, stall_errors);
        error_count = reset_errors + fetch_errors + write_errors + stall_errors + timeout_errors;
        $display("Totals: %0d checks, %0d errors",
                 reset_checks + fetch_checks + write_checks + stall_checks, error_count);
        done = 1'b1;
    end

    // Bus outputs must not move across a cycle with enable low
    always @(negedge clock)
    begin
        if (reset === 1'b0 && hold_pending)
        begin
            stall_checks++;
            if (address !== held_address || write_enable !== held_write
                || data_out !== held_data)
            begin
                $display("Mismatch at time %0t: bus moved in a stall, address %h was %h",
                         $time, address, held_address);
                stall_errors++;
            end
        end
        hold_pending = reset === 1'b0 && enable === 1'b0 && !done;
        held_address = address;
        held_write   = write_enable;
        held_data    = data_out;
    end

endmodule : cpu_checker

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_tb;

    logic        clock;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;
    logic        done;
    int          error_count;
    logic [7:0]  memory [0:65535]; // 64 KB memory model
    logic [31:0] rng_state;
    logic [15:0] image_pc;         // Next free byte of the program image
    int          cycle;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic emit_byte(input logic [7:0] value);
        memory[image_pc] = value;
        image_pc = image_pc + 16'd1;
    endtask

    task automatic build_program();
        int          addr;
        int          group;
        logic [31:0] r;
        logic [2:0]  op;
        logic [7:0]  opcode;
        logic [7:0]  zp_next;
        logic [15:0] target;
        for (addr = 0; addr < 65536; addr++)
            memory[addr] = 8'(addr) ^ 8'(addr >> 8) ^ 8'ha5; // Background fill
        memory[16'hfffc] = 8'h00;
        memory[16'hfffd] = 8'h02;   // Program starts at 0200
        image_pc = 16'h0200;
        zp_next  = 8'h10;           // Stores go to 10, 11, 12 and so on
        for (group = 0; group < 48; group++)
        begin
            r = next_random();
            case (r % 6)
                0, 1:
                begin
                    op = r[10:8] == 3'd4 ? 3'd5 : r[10:8]; // Any ALU op but STA
                    emit_byte({op, r[11] ? 3'b010 : 3'b001, 2'b01});
                    emit_byte(r[11] ? r[23:16] : {2'b00, r[21:16]});
                    emit_byte(8'h85);                       // STA shows the result
                    emit_byte(zp_next);
                    zp_next++;
                end
                2:
                begin
                    case (r[9:8])
                        2'd0:    opcode = 8'ha2;
                        2'd1:    opcode = 8'ha0;
                        2'd2:    opcode = 8'ha6;
                        default: opcode = 8'ha4;
                    endcase
                    emit_byte(opcode);
                    emit_byte(opcode[2] ? {2'b00, r[21:16]} : r[23:16]);
                    emit_byte(opcode[1] ? 8'h86 : 8'h84);  // Matching STX or STY
                    emit_byte(zp_next);
                    zp_next++;
                end
                3:
                begin
                    emit_byte(r[8] ? 8'h38 : 8'h18);
                    emit_byte(r[23:16]);                    // Read in byte2, ignored
                end
                4:
                begin
                    // Forward jump over a few fill bytes
                    target = image_pc + 16'd3 + 16'(r[9:8]);
                    emit_byte(8'h4c);
                    emit_byte(target[7:0]);
                    emit_byte(target[15:8]);
                    image_pc = target;
                end
                default:
                begin
                    emit_byte(r[8] ? 8'hea : 8'h89); // Opcodes outside the subset
                    emit_byte(r[23:16]);
                end
            endcase
        end
        target = image_pc;
        emit_byte(8'h4c);           // Final jump to itself
        emit_byte(target[7:0]);
        emit_byte(target[15:8]);
    endtask

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    assign data_in = memory[address]; // Same-cycle read

    always @(posedge clock)
    begin
        if (!reset && enable && write_enable)
            memory[address] <= data_out;
    end

    cpu_core cpu_core_inst (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync)
    );

    cpu_checker cpu_checker_inst (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync),
        .done         (done),
        .error_count  (error_count)
    );

    initial
    begin
        rng_state = 32'hdc90;
        reset     = 1'b1;
        enable    = 1'b1;
        build_program();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        cycle = 0;
        while (!done && cycle < 20000)
        begin
            @(posedge clock);
            enable <= (next_random() % 4) != 0; // About one stall in four
            cycle++;
        end
        if (!done)
            $display("Timeout: the checker did not finish within %0d cycles", cycle);
        if (done && error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : cpu_tb

`default_nettype wire

// ==== compile.f ====
rtl/cpu_pkg.sv
rtl/bus_input.sv
rtl/sequencer.sv
rtl/alu.sv
rtl/register_file.sv
rtl/bus_output.sv
rtl/cpu_core.sv
dv/cpu_checker.sv
dv/cpu_tb.sv
